// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f all.f --top-module cop0Tb -Mdir obj_dir
	./obj_dir/Vcop0Tb | tee /dev/stderr | grep -q "^Done: no errors$$"

clean:
	rm -rf obj_dir

// File: all.f
verilog/cop0Pkg.sv
verilog/cop0CmdDecode.sv
verilog/cop0IrqUnit.sv
verilog/cop0RegFile.sv
verilog/cop0RespQueue.sv
verilog/cop0Top.sv
tb/cop0Tb.sv

// File: tb/cop0Tb.sv
`timescale 1ns/10ps

module cop0Tb;

    import cop0Pkg::*;

    typedef enum int {ActNone, ActRaise, ActAck, ActLower, ActHold, ActRelease} action;

    typedef struct {
        action   act;
        cop0Cmd  cmd;
        cop0Resp exp;
        int      gap;
    } entry;

    localparam logic [DataWidth-1:0] TrapPc = 32'h8000_0180;

    logic                 Clock = 1'b0;
    logic                 arstN;
    logic                 cmdValid;
    cop0Cmd               cmd;
    logic                 cmdCredit;
    logic                 respValid;
    cop0Resp              resp;
    logic                 respCredit = 1'b0;
    logic [UartCount-1:0] irqLines;
    logic                 irqAck;
    logic [DataWidth-1:0] interruptedPc;
    logic                 irqRequest;

    entry    tests[$];
    cop0Resp expQ[$];
    int      hostCredits;
    int      heldCredits;   // Credits the DUT holds but has not spent yet.
    bit      withhold;
    bit      validInHold;
    int      seed = 32'hdb7940b3;
    int      cycles;
    int      errors;
    int      errorsBefore;
    int      checked;

    cop0Top UUT (.*);

    initial begin
        forever #2 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycles++;
        if (cycles > 40 * tests.size() + 200) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycles - 1);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic checkResp(input string name, input cop0Resp got, input cop0Resp exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected data %h write %b illegal %b, got %h %b %b",
                     $time, name, exp.data, exp.write, exp.illegal, got.data, got.write,
                     got.illegal);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    // Responses are compared in issue order, and credits go out only for responses still owed.
    always @(negedge Clock) begin
        if (arstN) begin
            if (cmdCredit) begin
                hostCredits++;
            end
            if (respValid) begin
                validInHold |= withhold;
                heldCredits--;
                if (expQ.size() == 0) begin
                    errors++;
                    $display("A response arrived that no command asked for.");
                end else begin
                    errorsBefore = errors;
                    checkResp("resp", resp, expQ.pop_front());
                    checked++;
                    $display("test %0d %s", checked,
                             (errors == errorsBefore) ? "passed" : "failed");
                end
            end
            respCredit = !withhold && (expQ.size() > heldCredits) && (($random(seed) & 1) == 0);
            if (respCredit) begin
                heldCredits++;
            end
        end
    end

    task automatic addTest(input action a, input logic w, input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata, input logic [DataWidth-1:0] rdata,
                           input logic bad, input int gap);
        entry e;
        e.act = a;
        e.cmd = '{write: w, addr: addr, data: wdata};
        e.exp = '{data: rdata, write: w, illegal: bad};
        e.gap = gap;
        tests.push_back(e);
    endtask

    task automatic buildTable();
        addTest(ActNone, 1'b0, AddrCompare, '0, CompareReset, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrStatus, '0, '0, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrCause, '0, '0, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrEpc, '0, '0, 1'b0, 0);
        addTest(ActNone, 1'b0, 5'd3, '0, '0, 1'b1, 0);
        addTest(ActNone, 1'b1, AddrEpc, 32'h1234, '0, 1'b1, 0);
        addTest(ActNone, 1'b1, AddrCompare, 32'h1_2345, 32'h1_2345, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrCompare, '0, 32'h1_2345, 1'b0, 0);
        addTest(ActNone, 1'b1, AddrCount, 32'd100, 32'd100, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrCount, '0, 32'd101, 1'b0, 2); // One increment per cycle.
        addTest(ActNone, 1'b1, AddrCause, 32'hFFFF_FFFF, 32'hFFFF_03FF, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrCause, '0, 32'hFFFF_03FF, 1'b0, 0);
        addTest(ActNone, 1'b1, AddrCause, '0, '0, 1'b0, 0);
        addTest(ActNone, 1'b1, AddrStatus, 32'h0401, 32'h0401, 1'b0, 3);
        addTest(ActRaise, 1'b0, AddrCause, '0, 32'h0400, 1'b0, 2);
        addTest(ActAck, 1'b0, AddrEpc, '0, TrapPc, 1'b0, 0);
        addTest(ActNone, 1'b1, AddrEpc, 32'h1234, '0, 1'b1, 0);
        addTest(ActNone, 1'b0, AddrStatus, '0, 32'h0400, 1'b0, 0);
        addTest(ActLower, 1'b1, AddrCause, '0, '0, 1'b0, 0);
        addTest(ActNone, 1'b1, AddrStatus, 32'h8000, 32'h8000, 1'b0, 0);
        addTest(ActNone, 1'b1, AddrCount, 32'd1000, 32'd1000, 1'b0, 0);
        addTest(ActNone, 1'b1, AddrCompare, 32'd1010, 32'd1010, 1'b0, 20);
        addTest(ActNone, 1'b0, AddrCause, '0, 32'h8000, 1'b0, 0);
        addTest(ActNone, 1'b1, AddrCompare, 32'h10_0000, 32'h10_0000, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrCause, '0, '0, 1'b0, 0);
        addTest(ActHold, 1'b0, AddrCompare, '0, 32'h10_0000, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrStatus, '0, 32'h8000, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrCause, '0, '0, 1'b0, 0);
        addTest(ActNone, 1'b0, AddrEpc, '0, TrapPc, 1'b0, 8);
        addTest(ActRelease, 1'b0, AddrCompare, '0, 32'h10_0000, 1'b0, 0);
    endtask

    task automatic applyAction(input action a);
        case (a)
            ActRaise: begin
                irqLines[0] = 1'b1;
                repeat (5) begin
                    if (!irqRequest) @(negedge Clock);
                end
                checkBit("irqRequest", irqRequest, 1'b1);
            end
            ActAck: begin
                irqAck = 1'b1;
                interruptedPc = TrapPc;
                @(negedge Clock);
                irqAck = 1'b0;
                checkBit("irqRequest", irqRequest, 1'b0);
            end
            ActLower: begin
                irqLines[0] = 1'b0;
                repeat (3) @(negedge Clock);
            end
            ActHold: begin
                while (expQ.size() != 0) @(negedge Clock);
                repeat (2) @(negedge Clock); // Lets the last command credit come back.
                withhold = 1'b1;
            end
            ActRelease: begin
                if (hostCredits != 0) begin
                    errors++;
                    $display("The host still had %0d command credits while held.", hostCredits);
                end
                if (validInHold) begin
                    errors++;
                    $display("A response was sent while no response credit was granted.");
                end
                withhold = 1'b0;
            end
            default: begin
            end
        endcase
    endtask

    task automatic issue(input cop0Cmd c, input cop0Resp e);
        while (hostCredits == 0) @(negedge Clock);
        cmdValid = 1'b1;
        cmd = c;
        hostCredits--;
        expQ.push_back(e);
        @(negedge Clock);
        cmdValid = 1'b0;
    endtask

    initial begin
        arstN = 1'b0;
        cmdValid = 1'b0;
        cmd = '0;
        irqLines = '0;
        irqAck = 1'b0;
        interruptedPc = '0;
        hostCredits = QueueDepth;
        heldCredits = 0;
        withhold = 1'b0;
        validInHold = 1'b0;
        cycles = 0;
        errors = 0;
        checked = 0;
        buildTable();
        repeat (3) @(negedge Clock);
        arstN = 1'b1;
        foreach (tests[i]) begin
            applyAction(tests[i].act);
            issue(tests[i].cmd, tests[i].exp);
            repeat (tests[i].gap) @(negedge Clock);
        end
        while (expQ.size() != 0) @(negedge Clock);
        repeat (3) @(negedge Clock);
        $display("%0d responses checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verilog/cop0CmdDecode.sv
`timescale 1ns/10ps

module cop0CmdDecode (
    input  logic               Clock,
    input  logic               arstN,
    input  logic               cmdValid,
    input  cop0Pkg::cop0Cmd    cmd,
    output logic               decValid,
    output cop0Pkg::cop0DecCmd dec
);

    import cop0Pkg::*;

    cop0RegSel sel;
    logic      illegal;

    always_comb begin
        case (cmd.addr)
            AddrCount:   sel = RegCount;
            AddrCompare: sel = RegCompare;
            AddrStatus:  sel = RegStatus;
            AddrCause:   sel = RegCause;
            AddrEpc:     sel = RegEpc;
            default:     sel = RegNone;
        endcase
    end

    // EPC is only loaded by an interrupt acknowledge.
    assign illegal = (sel == RegNone) || (cmd.write && (sel == RegEpc));

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= cmdValid;
        end
    end

    always_ff @(posedge Clock) begin
        if (cmdValid) begin
            dec.write   <= cmd.write;
            dec.sel     <= sel;
            dec.illegal <= illegal;
            dec.data    <= cmd.data;
        end
    end

endmodule

// File: verilog/cop0IrqUnit.sv
`timescale 1ns/10ps

module cop0IrqUnit (
    input  logic                           Clock,
    input  logic                           arstN,
    input  logic [cop0Pkg::UartCount-1:0]  irqLines,
    input  logic                           timerFire,
    input  logic                           countWrap,
    input  logic [cop0Pkg::IrqWidth-1:0]   pending,
    output logic [cop0Pkg::IrqWidth-1:0]   newPending
);

    import cop0Pkg::*;

    logic [UartCount-1:0] lineMeta;
    logic [UartCount-1:0] lineSync;
    logic [IrqWidth-1:0]  events;

    // Two flops per line because the lines come from another clock domain.
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            lineMeta <= '0;
            lineSync <= '0;
        end else begin
            lineMeta <= irqLines;
            lineSync <= lineMeta;
        end
    end

    // Timer on top, then wrap, spare bits, and the lines with line 0 lowest.
    assign events = {timerFire, countWrap, {(IrqWidth-2-UartCount){1'b0}}, lineSync};

    assign newPending = pending | events; // Pending bits stay until software clears them.

endmodule

// File: verilog/cop0Pkg.sv
package cop0Pkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 5;

    localparam logic [AddrWidth-1:0] AddrCount   = 5'd9;
    localparam logic [AddrWidth-1:0] AddrCompare = 5'd11;
    localparam logic [AddrWidth-1:0] AddrStatus  = 5'd12;
    localparam logic [AddrWidth-1:0] AddrCause   = 5'd13;
    localparam logic [AddrWidth-1:0] AddrEpc     = 5'd14;

    localparam int IrqWidth  = 6;     // Pending bits in Cause, mask bits in Status.
    localparam int IrqLsb    = 10;
    localparam int UartCount = 2;

    localparam int QueueDepth  = 4;
    localparam int CreditWidth = 8;   // Room for credits granted well ahead of need.

    localparam logic [DataWidth-1:0] CompareReset = 32'h0000_FFFF;

    typedef struct packed {
        logic                 write;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] data;
    } cop0Cmd;

    typedef enum logic [2:0] {
        RegNone,
        RegCount,
        RegCompare,
        RegStatus,
        RegCause,
        RegEpc
    } cop0RegSel;

    typedef struct packed {
        logic                 write;
        cop0RegSel            sel;
        logic                 illegal;
        logic [DataWidth-1:0] data;
    } cop0DecCmd;

    typedef struct packed {
        logic [DataWidth-1:0] data;
        logic                 write;
        logic                 illegal;
    } cop0Resp;

endpackage

// File: verilog/cop0RegFile.sv
`timescale 1ns/10ps

module cop0RegFile (
    input  logic                           Clock,
    input  logic                           arstN,
    input  logic                           decValid,
    input  cop0Pkg::cop0DecCmd             dec,
    input  logic [cop0Pkg::IrqWidth-1:0]   newPending,
    input  logic                           irqAck,
    input  logic [cop0Pkg::DataWidth-1:0]  interruptedPc,
    output logic                           exValid,
    output cop0Pkg::cop0Resp               exResp,
    output logic [cop0Pkg::IrqWidth-1:0]   pending,
    output logic                           timerFire,
    output logic                           countWrap,
    output logic                           irqRequest
);

    import cop0Pkg::*;

    logic [DataWidth-1:0] epc;
    logic [DataWidth-1:0] count;
    logic [DataWidth-1:0] compare;
    logic [DataWidth-1:0] status;
    logic [DataWidth-1:0] cause;

    logic [DataWidth-1:0] epcNext;
    logic [DataWidth-1:0] countNext;
    logic [DataWidth-1:0] compareNext;
    logic [DataWidth-1:0] statusNext;
    logic [DataWidth-1:0] causeNext;

    logic [IrqWidth-1:0]  mask;
    logic                 doWrite;
    logic [DataWidth-1:0] readData;

    assign doWrite = decValid && dec.write && !dec.illegal;

    assign pending    = cause[IrqLsb +: IrqWidth];
    assign mask       = status[IrqLsb +: IrqWidth];
    assign timerFire  = (count == compare);
    assign countWrap  = (count == '1);
    assign irqRequest = status[0] & |(mask & pending); // Bit 0 of Status is the global enable.

    always_comb begin
        epcNext     = epc;
        countNext   = count + 1'b1;
        compareNext = compare;
        statusNext  = status;
        causeNext   = cause;
        causeNext[IrqLsb +: IrqWidth] = newPending;
        if (doWrite) begin
            case (dec.sel)
                RegCount: begin
                    countNext = dec.data;
                end
                RegCompare: begin
                    compareNext = dec.data;
                    causeNext[IrqLsb+IrqWidth-1] = 1'b0; // Rearming the timer drops its request.
                end
                RegStatus: begin
                    statusNext = dec.data;
                end
                RegCause: begin
                    causeNext = dec.data;
                    // Software can clear pending bits but never set them.
                    causeNext[IrqLsb +: IrqWidth] = newPending & dec.data[IrqLsb +: IrqWidth];
                end
                default: begin
                end
            endcase
        end else if (irqAck) begin
            epcNext       = interruptedPc;
            statusNext[0] = 1'b0;
        end
    end

    // A response carries the register as it stands after this edge.
    always_comb begin
        case (dec.sel)
            RegCount:   readData = countNext;
            RegCompare: readData = compareNext;
            RegStatus:  readData = statusNext;
            RegCause:   readData = causeNext;
            RegEpc:     readData = epcNext;
            default:    readData = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            epc     <= '0;
            count   <= '0;
            compare <= CompareReset;
            status  <= '0;
            cause   <= '0;
            exValid <= 1'b0;
        end else begin
            epc     <= epcNext;
            count   <= countNext;
            compare <= compareNext;
            status  <= statusNext;
            cause   <= causeNext;
            exValid <= decValid;
        end
    end

    always_ff @(posedge Clock) begin
        if (decValid) begin
            exResp.data    <= dec.illegal ? '0 : readData;
            exResp.write   <= dec.write;
            exResp.illegal <= dec.illegal;
        end
    end

endmodule

// File: verilog/cop0RespQueue.sv
`timescale 1ns/10ps

module cop0RespQueue (
    input  logic             Clock,
    input  logic             arstN,
    input  logic             exValid,
    input  cop0Pkg::cop0Resp exResp,
    input  logic             respCredit,
    output logic             respValid,
    output cop0Pkg::cop0Resp resp,
    output logic             cmdCredit
);

    import cop0Pkg::*;

    cop0Resp mem [QueueDepth];

    logic [$clog2(QueueDepth)-1:0]   head;
    logic [$clog2(QueueDepth)-1:0]   tail;
    logic [$clog2(QueueDepth+1)-1:0] fill;
    logic [CreditWidth-1:0]          credits;
    logic                            pop;

    assign respValid = (fill != '0) && (credits != '0);
    assign pop       = respValid;   // The consumer has promised to take it.
    assign resp      = mem[head];

    always_ff @(posedge Clock) begin
        if (exValid) begin
            mem[tail] <= exResp;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            head      <= '0;
            tail      <= '0;
            fill      <= '0;
            credits   <= '0;
            cmdCredit <= 1'b0;
        end else begin
            if (exValid) begin
                tail <= (tail == QueueDepth-1) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == QueueDepth-1) ? '0 : head + 1'b1;
            end
            case ({exValid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            case ({respCredit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            cmdCredit <= pop;   // A freed slot goes back to the host.
        end
    end

endmodule

// File: verilog/cop0Top.sv
`timescale 1ns/10ps

module cop0Top (
    input  logic                           Clock,
    input  logic                           arstN,
    input  logic                           cmdValid,
    input  cop0Pkg::cop0Cmd                cmd,
    output logic                           cmdCredit,
    output logic                           respValid,
    output cop0Pkg::cop0Resp               resp,
    input  logic                           respCredit,
    input  logic [cop0Pkg::UartCount-1:0]  irqLines,
    input  logic                           irqAck,
    input  logic [cop0Pkg::DataWidth-1:0]  interruptedPc,
    output logic                           irqRequest
);

    import cop0Pkg::*;

    logic                decValid;
    cop0DecCmd           dec;
    logic                exValid;
    cop0Resp             exResp;
    logic [IrqWidth-1:0] pending;
    logic [IrqWidth-1:0] newPending;
    logic                timerFire;
    logic                countWrap;

    cop0CmdDecode decodeStage (
        .Clock    (Clock),
        .arstN    (arstN),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .decValid (decValid),
        .dec      (dec)
    );

    cop0IrqUnit irqUnit (
        .Clock      (Clock),
        .arstN      (arstN),
        .irqLines   (irqLines),
        .timerFire  (timerFire),
        .countWrap  (countWrap),
        .pending    (pending),
        .newPending (newPending)
    );

    cop0RegFile regStage (
        .Clock         (Clock),
        .arstN         (arstN),
        .decValid      (decValid),
        .dec           (dec),
        .newPending    (newPending),
        .irqAck        (irqAck),
        .interruptedPc (interruptedPc),
        .exValid       (exValid),
        .exResp        (exResp),
        .pending       (pending),
        .timerFire     (timerFire),
        .countWrap     (countWrap),
        .irqRequest    (irqRequest)
    );

    cop0RespQueue respStage (
        .Clock      (Clock),
        .arstN      (arstN),
        .exValid    (exValid),
        .exResp     (exResp),
        .respCredit (respCredit),
        .respValid  (respValid),
        .resp       (resp),
        .cmdCredit  (cmdCredit)
    );

endmodule
